//--- source/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Bus widths
    localparam int addr_bits = 16;
    localparam int data_bits = 32;

    // Memory map, byte addresses
    localparam logic [addr_bits-1:0] rom_base = 16'h0000;
    localparam int rom_words = 1024;
    localparam logic [addr_bits-1:0] ram_base = 16'h1000;
    localparam int ram_words = 2048;
    localparam int mem_words = rom_words + ram_words;
    localparam int mem_idx_bits = $clog2(mem_words);

    // Peripheral registers
    localparam logic [addr_bits-1:0] console_addr = 16'h3000;
    localparam logic [addr_bits-1:0] key_addr = 16'h3004;
    localparam int console_depth = 4;

    // Interrupt vectors, lower number wins
    localparam int irq_vector_bits = 4;
    localparam logic [irq_vector_bits-1:0] irq_key = 4'd1;
    localparam logic [irq_vector_bits-1:0] irq_console = 4'd2;

    // AXI response codes
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_t;

    typedef enum logic [1:0] {
        br_idle,
        br_access,
        br_respond
    } bridge_state_t;

    typedef enum logic [1:0] {
        ps2_idle,
        ps2_data,
        ps2_parity,
        ps2_stop
    } ps2_state_t;

endpackage

`default_nettype wire

//--- source/periph_if.sv
`timescale 1ns/1ps
`default_nettype none

// One request per access, reply on the following cycle
interface periph_if import soc_pkg::*; ();

    logic                 req;
    logic                 we;
    logic [addr_bits-1:0] addr;
    logic [data_bits-1:0] wdata;
    logic [data_bits-1:0] rdata;
    logic                 err;

    modport bridge (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  err
    );

    modport target (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output err
    );

endinterface

`default_nettype wire

//--- source/code_ram.sv
`timescale 1ns/1ps
`default_nettype none

module code_ram import soc_pkg::*; (
    input  logic     CLOCK_50,
    periph_if.target bus
);

    // ROM words first, RAM follows directly behind
    logic [data_bits-1:0] mem [mem_words];
    logic [mem_idx_bits-1:0] word;
    logic in_rom;

    assign word   = bus.addr[mem_idx_bits+1:2];
    assign in_rom = (bus.addr >= rom_base)
                 && (bus.addr < rom_base + addr_bits'(rom_words * 4));

    initial begin
        $readmemh("boot.hex", mem, rom_base >> 2);
    end

    // Read-during-write returns the old word
    always_ff @(posedge CLOCK_50) begin
        if (bus.req) begin
            bus.rdata <= mem[word];
            if (bus.we && !in_rom) begin
                mem[word] <= bus.wdata;
            end
        end
        bus.err <= bus.req && bus.we && in_rom;
    end

endmodule

`default_nettype wire

//--- source/ps2_key_port.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_key_port import soc_pkg::*; (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     ps2_clk,
    input  logic     ps2_dat,
    periph_if.target bus,
    output logic     key_event
);

    ps2_state_t state;
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic clk_prev;
    logic [7:0] shift;
    logic [2:0] bit_cnt;
    logic par_ok;
    logic break_seen;
    logic new_flag;
    logic [7:0] key_code;

    logic fall;
    logic rd_clear;

    assign fall     = clk_prev && !clk_sync[1];
    assign rd_clear = bus.req && !bus.we;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= ps2_idle;
            clk_sync   <= 2'b11;
            dat_sync   <= 2'b11;
            clk_prev   <= 1'b1;
            shift      <= '0;
            bit_cnt    <= '0;
            par_ok     <= 1'b0;
            break_seen <= 1'b0;
            new_flag   <= 1'b0;
            key_code   <= '0;
            key_event  <= 1'b0;
            bus.err    <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            dat_sync  <= {dat_sync[0], ps2_dat};
            clk_prev  <= clk_sync[1];
            key_event <= 1'b0;
            bus.err   <= bus.req && bus.we;
            if (rd_clear) begin
                new_flag <= 1'b0;
            end
            if (fall) begin
                case (state)
                    ps2_idle: begin
                        // Start bit is low
                        if (!dat_sync[1]) begin
                            bit_cnt <= '0;
                            state   <= ps2_data;
                        end
                    end
                    ps2_data: begin
                        shift   <= {dat_sync[1], shift[7:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= ps2_parity;
                        end
                    end
                    ps2_parity: begin
                        // Odd parity over data and parity bit
                        par_ok <= ^{dat_sync[1], shift};
                        state  <= ps2_stop;
                    end
                    ps2_stop: begin
                        state <= ps2_idle;
                        if (dat_sync[1] && par_ok) begin
                            if (shift == 8'hf0) begin
                                break_seen <= 1'b1;
                            end else if (break_seen) begin
                                break_seen <= 1'b0;
                            end else begin
                                key_code  <= shift;
                                new_flag  <= 1'b1;
                                key_event <= 1'b1;
                            end
                        end
                    end
                    default: state <= ps2_idle;
                endcase
            end
        end
    end

    // Flag in bit 8, code below
    always_ff @(posedge CLOCK_50) begin
        if (bus.req) begin
            bus.rdata <= data_bits'({new_flag, key_code});
        end
    end

endmodule

`default_nettype wire

//--- source/console_port.sv
`timescale 1ns/1ps
`default_nettype none

module console_port import soc_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    periph_if.target   bus,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready,
    output logic       drained
);

    logic [7:0] fifo [console_depth];
    logic [$clog2(console_depth)-1:0] wr_ptr;
    logic [$clog2(console_depth)-1:0] rd_ptr;
    logic [$clog2(console_depth):0] count;

    logic full;
    logic push;
    logic pop;

    // Count reaches depth only with its top bit set
    assign full     = count[$clog2(console_depth)];
    assign push     = bus.req && bus.we && !full;
    assign pop      = tx_valid && tx_ready;
    assign tx_valid = count != '0;
    assign tx_data  = fifo[rd_ptr];
    assign drained  = pop && !push && (count == 1);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            bus.err <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // Dropped byte
            bus.err <= bus.req && bus.we && full;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (push) begin
            fifo[wr_ptr] <= bus.wdata[7:0];
        end
        if (bus.req) begin
            bus.rdata <= data_bits'(count);
        end
    end

endmodule

`default_nettype wire

//--- source/irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl import soc_pkg::*; (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic                       key_event,
    input  logic                       drained,
    output logic [irq_vector_bits-1:0] irq_vector,
    input  logic                       irq_ack
);

    // One pending bit per vector number
    logic [irq_console:irq_key] pending;
    logic [irq_console:irq_key] pend_next;
    logic ack;

    assign ack = irq_ack && (irq_vector != '0);

    always_comb begin
        pend_next = pending;
        if (ack && irq_vector == irq_key) begin
            pend_next[irq_key] = 1'b0;
        end
        if (ack && irq_vector == irq_console) begin
            pend_next[irq_console] = 1'b0;
        end
        pend_next[irq_key]     = pend_next[irq_key] || key_event;
        pend_next[irq_console] = pend_next[irq_console] || drained;
    end

    // Vector is held until acknowledged, the next one follows a cycle later
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending    <= '0;
            irq_vector <= '0;
        end else begin
            pending <= pend_next;
            if (ack) begin
                irq_vector <= '0;
            end else if (irq_vector == '0) begin
                if (pend_next[irq_key]) begin
                    irq_vector <= irq_key;
                end else if (pend_next[irq_console]) begin
                    irq_vector <= irq_console;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/axil_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axil_bridge import soc_pkg::*; (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [addr_bits-1:0] awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  logic [data_bits-1:0] wdata,
    output logic                 bvalid,
    input  logic                 bready,
    output logic [1:0]           bresp,
    input  logic                 arvalid,
    output logic                 arready,
    input  logic [addr_bits-1:0] araddr,
    output logic                 rvalid,
    input  logic                 rready,
    output logic [data_bits-1:0] rdata,
    output logic [1:0]           rresp,
    periph_if.bridge             mem_bus,
    periph_if.bridge             con_bus,
    periph_if.bridge             key_bus
);

    bridge_state_t state;
    logic issued;
    logic we_q;
    logic sel_mem;
    logic sel_con;
    logic sel_key;
    resp_t resp_q;
    logic [addr_bits-1:0] addr_q;
    logic [data_bits-1:0] wdata_q;
    logic [data_bits-1:0] rdata_q;

    logic issue;
    logic [addr_bits-1:0] dec_addr;
    logic hit_mem;
    logic hit_con;
    logic hit_key;
    logic [data_bits-1:0] tgt_rdata;
    logic tgt_err;

    // Reads win, a write needs both address and data
    assign arready = (state == br_idle) && arvalid;
    assign awready = (state == br_idle) && awvalid && wvalid && !arvalid;
    assign wready  = awready;

    assign dec_addr = arvalid ? araddr : awaddr;
    assign hit_mem  = (dec_addr >= rom_base && dec_addr < rom_base + addr_bits'(rom_words * 4))
                   || (dec_addr >= ram_base && dec_addr < ram_base + addr_bits'(ram_words * 4));
    assign hit_con  = dec_addr == console_addr;
    assign hit_key  = dec_addr == key_addr;

    // Request lasts the first access cycle only
    assign issue         = (state == br_access) && !issued;
    assign mem_bus.req   = issue && sel_mem;
    assign con_bus.req   = issue && sel_con;
    assign key_bus.req   = issue && sel_key;
    assign mem_bus.we    = we_q;
    assign con_bus.we    = we_q;
    assign key_bus.we    = we_q;
    assign mem_bus.addr  = addr_q;
    assign con_bus.addr  = addr_q;
    assign key_bus.addr  = addr_q;
    assign mem_bus.wdata = wdata_q;
    assign con_bus.wdata = wdata_q;
    assign key_bus.wdata = wdata_q;

    // Unmapped leaves data at zero
    always_comb begin
        tgt_rdata = '0;
        tgt_err   = 1'b0;
        if (sel_mem) begin
            tgt_rdata = mem_bus.rdata;
            tgt_err   = mem_bus.err;
        end else if (sel_con) begin
            tgt_rdata = con_bus.rdata;
            tgt_err   = con_bus.err;
        end else if (sel_key) begin
            tgt_rdata = key_bus.rdata;
            tgt_err   = key_bus.err;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state   <= br_idle;
            issued  <= 1'b0;
            we_q    <= 1'b0;
            sel_mem <= 1'b0;
            sel_con <= 1'b0;
            sel_key <= 1'b0;
            resp_q  <= resp_okay;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            case (state)
                br_idle: begin
                    if (arready || awready) begin
                        we_q    <= !arready;
                        sel_mem <= hit_mem;
                        sel_con <= hit_con;
                        sel_key <= hit_key;
                        issued  <= 1'b0;
                        state   <= br_access;
                    end
                end
                br_access: begin
                    if (!issued) begin
                        issued <= 1'b1;
                    end else begin
                        if (!(sel_mem || sel_con || sel_key)) begin
                            resp_q <= resp_decerr;
                        end else if (tgt_err) begin
                            resp_q <= resp_slverr;
                        end else begin
                            resp_q <= resp_okay;
                        end
                        bvalid <= we_q;
                        rvalid <= !we_q;
                        state  <= br_respond;
                    end
                end
                br_respond: begin
                    // Held here under back-pressure
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        state  <= br_idle;
                    end
                end
                default: state <= br_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == br_idle) begin
            addr_q  <= dec_addr;
            wdata_q <= wdata;
        end
        if (state == br_access && issued) begin
            rdata_q <= tgt_rdata;
        end
    end

    assign bresp = resp_q;
    assign rresp = resp_q;
    assign rdata = rdata_q;

endmodule

`default_nettype wire

//--- source/soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus import soc_pkg::*; (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [addr_bits-1:0]       awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [data_bits-1:0]       wdata,
    output logic                       bvalid,
    input  logic                       bready,
    output logic [1:0]                 bresp,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [addr_bits-1:0]       araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output logic [data_bits-1:0]       rdata,
    output logic [1:0]                 rresp,
    input  logic                       ps2_clk,
    input  logic                       ps2_dat,
    output logic [7:0]                 tx_data,
    output logic                       tx_valid,
    input  logic                       tx_ready,
    output logic [irq_vector_bits-1:0] irq_vector,
    input  logic                       irq_ack
);

    logic key_event;
    logic drained;

    periph_if mem_bus ();
    periph_if con_bus ();
    periph_if key_bus ();

    axil_bridge u_bridge (
        .CLOCK_50, .KEY0,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .mem_bus, .con_bus, .key_bus
    );

    code_ram u_ram (
        .CLOCK_50,
        .bus (mem_bus)
    );

    console_port u_console (
        .CLOCK_50, .KEY0,
        .bus (con_bus),
        .tx_data, .tx_valid, .tx_ready,
        .drained
    );

    ps2_key_port u_keys (
        .CLOCK_50, .KEY0,
        .ps2_clk, .ps2_dat,
        .bus (key_bus),
        .key_event
    );

    irq_ctrl u_irq (
        .CLOCK_50, .KEY0,
        .key_event, .drained,
        .irq_vector, .irq_ack
    );

endmodule

`default_nettype wire

//--- verif/tb_soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

    localparam int clk_half = 4;
    localparam int ps2_half = 4;

    // Edges from the falling PS/2 clock to the key source pulse
    localparam int key_src_delay = 3;

    // Run length with a factor of two as margin
    localparam int num_txns = 64;
    localparam int txn_cycles = 8;
    localparam int num_frames = 6;
    localparam int frame_cycles = 12 * 2 * ps2_half + 8;
    localparam int timeout_cycles = 2 * (num_txns * txn_cycles
                                       + num_frames * frame_cycles + 100);

    // AXI response codes
    localparam logic [1:0] okay   = 2'b00;
    localparam logic [1:0] slverr = 2'b10;
    localparam logic [1:0] decerr = 2'b11;

    localparam logic [15:0] ram_start = 16'h1000;
    localparam logic [15:0] con_reg   = 16'h3000;
    localparam logic [15:0] key_reg   = 16'h3004;

    logic        CLOCK_50;
    logic        KEY0;
    logic        awvalid;
    logic        awready;
    logic [15:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [15:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        ps2_clk;
    logic        ps2_dat;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_ready;
    logic [3:0]  irq_vector;
    logic        irq_ack;

    logic [31:0] boot_img [16];
    logic [7:0]  con_expect [$];
    logic [15:0] ram_addr [8];
    logic [31:0] ram_data [8];
    integer      seed = 73296;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    soc_bus soc_bus_i (
        .CLOCK_50, .KEY0,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .ps2_clk, .ps2_dat,
        .tx_data, .tx_valid, .tx_ready,
        .irq_vector, .irq_ack
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #clk_half CLOCK_50 = ~CLOCK_50;
    end

    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("Timeout: no result after %0d clock cycles", timeout_cycles);
        $display("Test FAILED");
        $finish;
    end

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(negedge CLOCK_50);
        while (!(awready && wready)) @(negedge CLOCK_50);
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge CLOCK_50);
        while (!bvalid) @(negedge CLOCK_50);
        check_eq($sformatf("bresp for write to %h", addr), 32'(bresp), 32'(exp_resp));
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [15:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge CLOCK_50);
        while (!arready) @(negedge CLOCK_50);
        next_cycle();
        arvalid = 1'b0;
        @(negedge CLOCK_50);
        while (!rvalid) @(negedge CLOCK_50);
        check_eq($sformatf("rresp for read of %h", addr), 32'(rresp), 32'(exp_resp));
        check_eq($sformatf("rdata for read of %h", addr), rdata, exp_data);
        next_cycle();
        rready = 1'b0;
    endtask

    // Start bit, eight data bits LSB first, odd parity and stop bit
    // With drain set the last console byte leaves as the key source pulses
    task automatic ps2_send(input logic [7:0] code, input logic bad_par,
                            input logic drain);
        logic [10:0] frame;
        frame = {1'b1, (~(^code)) ^ bad_par, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = frame[i];
            wait_cycles(ps2_half);
            ps2_clk = 1'b0;
            if (drain && i == 10) begin
                wait_cycles(key_src_delay);
                tx_ready = 1'b1;
                next_cycle();
                tx_ready = 1'b0;
                wait_cycles(ps2_half - key_src_delay - 1);
            end else begin
                wait_cycles(ps2_half);
            end
            ps2_clk = 1'b1;
        end
        wait_cycles(ps2_half);
    endtask

    task automatic check_vector(input logic [3:0] exp);
        @(negedge CLOCK_50);
        check_eq("irq_vector", 32'(irq_vector), 32'(exp));
        next_cycle();
    endtask

    task automatic ack_irq();
        irq_ack = 1'b1;
        next_cycle();
        irq_ack = 1'b0;
    endtask

    // Take every queued byte off the stream in order
    task automatic drain_console();
        tx_ready = 1'b1;
        while (con_expect.size() > 0) begin
            @(negedge CLOCK_50);
            if (tx_valid) begin
                check_eq("tx_data", 32'(tx_data), 32'(con_expect.pop_front()));
            end
        end
        next_cycle();
        tx_ready = 1'b0;
    endtask

    task automatic test_reset_state();
        @(negedge CLOCK_50);
        check_eq("bvalid after reset", 32'(bvalid), 32'd0);
        check_eq("rvalid after reset", 32'(rvalid), 32'd0);
        check_eq("tx_valid after reset", 32'(tx_valid), 32'd0);
        check_eq("awready after reset", 32'(awready), 32'd0);
        check_eq("wready after reset", 32'(wready), 32'd0);
        check_eq("arready after reset", 32'(arready), 32'd0);
        check_eq("irq_vector after reset", 32'(irq_vector), 32'd0);
        next_cycle();
    endtask

    task automatic test_memory();
        for (int i = 0; i < 16; i++) begin
            axi_read(16'(i * 4), boot_img[i], okay);
        end
        // One random word in each 256-word slot of RAM
        for (int i = 0; i < 8; i++) begin
            ram_addr[i] = ram_start + 16'((i * 256 + ($random(seed) & 255)) * 4);
            ram_data[i] = $random(seed);
            axi_write(ram_addr[i], ram_data[i], okay);
        end
        for (int i = 0; i < 8; i++) begin
            axi_read(ram_addr[i], ram_data[i], okay);
        end
        ram_data[3] = $random(seed);
        axi_write(ram_addr[3], ram_data[3], okay);
        for (int i = 0; i < 8; i++) begin
            axi_read(ram_addr[i], ram_data[i], okay);
        end
    endtask

    task automatic test_errors();
        axi_write(16'h0010, 32'hdeadbeef, slverr);
        axi_read(16'h0010, boot_img[4], okay);
        axi_read(16'h4000, 32'h0, decerr);
        axi_read(16'h3008, 32'h0, decerr);
        axi_write(16'h3008, 32'h1234, decerr);
    endtask

    task automatic test_console();
        logic [7:0] b;
        for (int i = 0; i < 4; i++) begin
            b = 8'h41 + 8'(i);
            con_expect.push_back(b);
            axi_write(con_reg, {24'habcdef, b}, okay);
        end
        @(negedge CLOCK_50);
        check_eq("tx_valid with data queued", 32'(tx_valid), 32'd1);
        check_eq("tx_data head", 32'(tx_data), 32'(con_expect[0]));
        next_cycle();
        axi_read(con_reg, 32'd4, okay);
        // Full FIFO drops the byte
        axi_write(con_reg, 32'h5a, slverr);
        axi_read(con_reg, 32'd4, okay);
        drain_console();
        check_vector(4'd2);
        axi_read(con_reg, 32'd0, okay);
        ack_irq();
        check_vector(4'd0);
    endtask

    task automatic test_keys();
        ps2_send(8'h1c, 1'b0, 1'b0);
        wait_cycles(4);
        check_vector(4'd1);
        axi_read(key_reg, 32'h11c, okay);
        axi_read(key_reg, 32'h01c, okay);
        axi_write(key_reg, 32'h0, slverr);
        ack_irq();
        check_vector(4'd0);
        ps2_send(8'h5a, 1'b1, 1'b0);
        wait_cycles(4);
        check_vector(4'd0);
        axi_read(key_reg, 32'h01c, okay);
        // Code after the F0 prefix is ignored
        ps2_send(8'hf0, 1'b0, 1'b0);
        ps2_send(8'h33, 1'b0, 1'b0);
        wait_cycles(4);
        check_vector(4'd0);
        axi_read(key_reg, 32'h01c, okay);
    endtask

    task automatic test_irq_priority();
        // One byte waits in the FIFO so both sources rise in the same cycle
        axi_write(con_reg, 32'h7e, okay);
        ps2_send(8'h2b, 1'b0, 1'b1);
        wait_cycles(4);
        check_vector(4'd1);
        ack_irq();
        check_vector(4'd0);
        check_vector(4'd2);
        ack_irq();
        check_vector(4'd0);
        check_vector(4'd0);
        axi_read(con_reg, 32'd0, okay);
        axi_read(key_reg, 32'h12b, okay);
    endtask

    initial begin
        KEY0     = 1'b0;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        ps2_clk  = 1'b1;
        ps2_dat  = 1'b1;
        tx_ready = 1'b0;
        irq_ack  = 1'b0;
        $readmemh("boot.hex", boot_img);
        repeat (3) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        test_reset_state();
        test_memory();
        test_errors();
        test_console();
        test_keys();
        test_irq_priority();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- boot.hex
// One 32-bit instruction word per line, loaded from ROM word 0 upward
00001137
00003537
04800593
00b52023
06900593
00b52023
00452603
10067693
fe068ce3
0ff67613
00c52023
fe5ff06f
00000013
00000013
00000013
00000013

//--- soc_bus.f
source/soc_pkg.sv
source/periph_if.sv
source/code_ram.sv
source/ps2_key_port.sv
source/console_port.sv
source/irq_ctrl.sv
source/axil_bridge.sv
source/soc_bus.sv
verif/tb_soc_bus.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = tb_soc_bus
FILELIST = soc_bus.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
